//--- cpu_macros.svh
// Datapath width, register count and register address width
// for the three-stage core

`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath width in bits
`define DATA_W 16

// Register file depth
`define REG_CNT 16

// Register address width
`define REG_AW 4

`endif

//--- isa_pkg.sv
// Instruction word union with register and immediate views
// Opcode constants of the instruction set

`default_nettype none

package isa_pkg;

	// One 16-bit word, read two ways depending on the opcode
	typedef union packed {
		// Register form, src0 also carries the shift amount
		struct packed {
			logic [3:0] opcode;
			logic [3:0] dst;
			logic [3:0] src1;
			logic [3:0] src0;
		} r;
		// Immediate form for lhb and llb
		struct packed {
			logic [3:0] opcode;
			logic [3:0] dst;
			logic [7:0] imm;
		} i;
	} instrU;

	// Arithmetic and logic
	localparam logic [3:0] opAdd  = 4'h0;
	localparam logic [3:0] opAddz = 4'h1;
	localparam logic [3:0] opSub  = 4'h2;
	localparam logic [3:0] opAnd  = 4'h3;
	localparam logic [3:0] opNor  = 4'h4;

	// Shifts
	localparam logic [3:0] opSll  = 4'h5;
	localparam logic [3:0] opSrl  = 4'h6;
	localparam logic [3:0] opSra  = 4'h7;

	// Byte loads
	localparam logic [3:0] opLhb  = 4'ha;
	localparam logic [3:0] opLlb  = 4'hb;

	// Stop the core
	localparam logic [3:0] opHlt  = 4'hf;

endpackage

`default_nettype wire

//--- alu_pkg.sv
// ALU function codes
// Bit positions inside the 3-bit flag word

`default_nettype none

package alu_pkg;

	// Function codes produced by the decoder
	localparam logic [2:0] fnAdd = 3'b000;
	localparam logic [2:0] fnSub = 3'b001;
	localparam logic [2:0] fnAnd = 3'b010;
	localparam logic [2:0] fnNor = 3'b011;
	localparam logic [2:0] fnSll = 3'b100;
	localparam logic [2:0] fnSrl = 3'b101;
	localparam logic [2:0] fnLhb = 3'b110;
	localparam logic [2:0] fnSra = 3'b111;

	// Flag word layout {N, Z, V}
	localparam int flagN = 2;
	localparam int flagZ = 1;
	localparam int flagV = 0;

endpackage

`default_nettype wire

//--- instr_decode.sv
// First pipeline stage
// Registered decode of one instruction word into control and addresses

`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module instr_decode import isa_pkg::*, alu_pkg::*; (
	input  logic                clk,
	input  logic                arstN,
	input  logic                instrValid,
	input  instrU               instr,
	output logic                dValid,
	output logic [2:0]          dFunc,
	output logic [`REG_AW-1:0]  dDst,
	output logic [`REG_AW-1:0]  dRs0,
	output logic [`REG_AW-1:0]  dRs1,
	output logic                dRe0,
	output logic                dRe1,
	output logic                dImmSel,
	output logic [7:0]          dImm,
	output logic [3:0]          dShamt,
	output logic                dWe,
	output logic                dCond,
	output logic                dHlt
);

	// Valid bit, gaps become bubbles
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			dValid <= 1'b0;
		end else begin
			dValid <= instrValid;
		end
	end

	// Decode table, loaded only with a new instruction
	always_ff @(posedge clk) begin
		if (instrValid) begin
			// Field extraction common to every opcode
			dDst    <= instr.r.dst;
			dRs1    <= instr.r.src1;
			dRs0    <= instr.r.src0;
			dImm    <= instr.i.imm;
			dShamt  <= instr.r.src0;
			// Defaults give a no-write bubble
			dFunc   <= fnAdd;
			dRe0    <= 1'b0;
			dRe1    <= 1'b0;
			dImmSel <= 1'b0;
			dWe     <= 1'b0;
			dCond   <= 1'b0;
			dHlt    <= 1'b0;
			case (instr.r.opcode)
				opAdd, opAddz, opSub, opAnd, opNor: begin
					dRe0 <= 1'b1;
					dRe1 <= 1'b1;
					dWe  <= 1'b1;
					// addz only marked here, Z tested in execute
					dCond <= (instr.r.opcode == opAddz);
					case (instr.r.opcode)
						opSub:   dFunc <= fnSub;
						opAnd:   dFunc <= fnAnd;
						opNor:   dFunc <= fnNor;
						default: dFunc <= fnAdd;
					endcase
				end
				opSll, opSrl, opSra: begin
					// Shift src1, src0 is the amount
					dRe1 <= 1'b1;
					dWe  <= 1'b1;
					case (instr.r.opcode)
						opSrl:   dFunc <= fnSrl;
						opSra:   dFunc <= fnSra;
						default: dFunc <= fnSll;
					endcase
				end
				opLhb: begin
					// Operand is the old dst value
					dRs0    <= instr.r.dst;
					dRe0    <= 1'b1;
					dRe1    <= 1'b1;
					dImmSel <= 1'b1;
					dShamt  <= 4'd8;
					dFunc   <= fnLhb;
					dWe     <= 1'b1;
				end
				opLlb: begin
					// No register reads, immediate passes unshifted
					dImmSel <= 1'b1;
					dShamt  <= 4'd0;
					dFunc   <= fnLhb;
					dWe     <= 1'b1;
				end
				opHlt: dHlt <= 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- reg_file.sv
// Sixteen-entry register file
// Two asynchronous read ports with write-through, one write port

`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module reg_file (
	input  logic               clk,
	input  logic               arstN,
	input  logic [`REG_AW-1:0] rdAddr0,
	input  logic [`REG_AW-1:0] rdAddr1,
	output logic [`DATA_W-1:0] rdData0,
	output logic [`DATA_W-1:0] rdData1,
	input  logic               wrEn,
	input  logic [`REG_AW-1:0] wrAddr,
	input  logic [`DATA_W-1:0] wrData
);

	logic [`DATA_W-1:0] regs [`REG_CNT];

	// Register 0 is writable like any other
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regs <= '{default: '0};
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Same-cycle write shows up on the read ports
	always_comb begin
		if (wrEn && (wrAddr == rdAddr0)) begin
			rdData0 = wrData;
		end else begin
			rdData0 = regs[rdAddr0];
		end
		if (wrEn && (wrAddr == rdAddr1)) begin
			rdData1 = wrData;
		end else begin
			rdData1 = regs[rdAddr1];
		end
	end

endmodule

`default_nettype wire

//--- operand_stage.sv
// Second pipeline stage
// Register reads, forwarding from execute and immediate select

`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module operand_stage (
	input  logic               clk,
	input  logic               arstN,
	input  logic               dValid,
	input  logic [2:0]         dFunc,
	input  logic [`REG_AW-1:0] dDst,
	input  logic [`REG_AW-1:0] dRs0,
	input  logic [`REG_AW-1:0] dRs1,
	input  logic               dRe0,
	input  logic               dRe1,
	input  logic               dImmSel,
	input  logic [7:0]         dImm,
	input  logic [3:0]         dShamt,
	input  logic               dWe,
	input  logic               dCond,
	input  logic               dHlt,
	output logic [`REG_AW-1:0] rdAddr0,
	output logic [`REG_AW-1:0] rdAddr1,
	input  logic [`DATA_W-1:0] rdData0,
	input  logic [`DATA_W-1:0] rdData1,
	input  logic               fwdValid,
	input  logic [`REG_AW-1:0] fwdAddr,
	input  logic [`DATA_W-1:0] fwdData,
	output logic               oValid,
	output logic [2:0]         oFunc,
	output logic [`REG_AW-1:0] oDst,
	output logic [`DATA_W-1:0] oA,
	output logic [`DATA_W-1:0] oB,
	output logic [3:0]         oShamt,
	output logic               oWe,
	output logic               oCond,
	output logic               oHlt
);

	logic [`DATA_W-1:0] immExt;
	logic [`DATA_W-1:0] opA;
	logic [`DATA_W-1:0] opB;

	assign rdAddr0 = dRs0;
	assign rdAddr1 = dRs1;

	// Sign-extended byte immediate
	assign immExt = {{(`DATA_W-8){dImm[7]}}, dImm};

	// Operand A, the src1 side, also takes the immediate
	// fwdValid already folds in the addz and halt checks
	always_comb begin
		if (dImmSel) begin
			opA = immExt;
		end else if (!dRe1) begin
			opA = '0;
		end else if (fwdValid && (fwdAddr == dRs1)) begin
			opA = fwdData;
		end else begin
			opA = rdData1;
		end
	end

	// Operand B never carries the immediate, lhb needs old dst here
	always_comb begin
		if (!dRe0) begin
			opB = '0;
		end else if (fwdValid && (fwdAddr == dRs0)) begin
			opB = fwdData;
		end else begin
			opB = rdData0;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			oValid <= 1'b0;
		end else begin
			oValid <= dValid;
		end
	end

	// Payload follows the valid bit
	always_ff @(posedge clk) begin
		if (dValid) begin
			oFunc  <= dFunc;
			oDst   <= dDst;
			oA     <= opA;
			oB     <= opB;
			oShamt <= dShamt;
			oWe    <= dWe;
			oCond  <= dCond;
			oHlt   <= dHlt;
		end
	end

endmodule

`default_nettype wire

//--- execute_stage.sv
// Third pipeline stage
// ALU, flag register, conditional write, halt state, write-back register

`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module execute_stage import alu_pkg::*; (
	input  logic               clk,
	input  logic               arstN,
	input  logic               oValid,
	input  logic [2:0]         oFunc,
	input  logic [`REG_AW-1:0] oDst,
	input  logic [`DATA_W-1:0] oA,
	input  logic [`DATA_W-1:0] oB,
	input  logic [3:0]         oShamt,
	input  logic               oWe,
	input  logic               oCond,
	input  logic               oHlt,
	output logic               fwdValid,
	output logic [`DATA_W-1:0] fwdData,
	output logic               wbValid,
	output logic [`REG_AW-1:0] wbAddr,
	output logic [`DATA_W-1:0] wbData,
	output logic [2:0]         flags,
	output logic               halted
);

	logic [`DATA_W-1:0] aluRes;
	logic               ovf;
	logic               arith;
	logic               flagEn;
	logic               willWrite;
	logic [2:0]         nextFlags;

	// ALU
	always_comb begin
		aluRes = '0;
		ovf    = 1'b0;
		case (oFunc)
			fnAdd: begin
				aluRes = oA + oB;
				// Same-sign inputs, result sign differs
				ovf = (oA[`DATA_W-1] == oB[`DATA_W-1]) &&
				      (aluRes[`DATA_W-1] != oA[`DATA_W-1]);
			end
			fnSub: begin
				aluRes = oA - oB;
				ovf = (oA[`DATA_W-1] != oB[`DATA_W-1]) &&
				      (aluRes[`DATA_W-1] != oA[`DATA_W-1]);
			end
			fnAnd: aluRes = oA & oB;
			fnNor: aluRes = ~(oA | oB);
			fnSll: aluRes = oA << oShamt;
			fnSrl: aluRes = oA >> oShamt;
			fnSra: aluRes = $unsigned($signed(oA) >>> oShamt);
			// lhb shifts imm by 8 over old low byte, llb by 0 over zero
			fnLhb: aluRes = (oA << oShamt) | {{(`DATA_W-8){1'b0}}, oB[7:0]};
			default: aluRes = '0;
		endcase
	end

	// Byte loads keep flags, halt and bubbles too
	assign arith  = (oFunc == fnAdd) || (oFunc == fnSub);
	assign flagEn = oValid && oWe && !halted && (oFunc != fnLhb);

	// A suppressed addz still updates flags
	always_comb begin
		nextFlags = flags;
		if (flagEn) begin
			nextFlags[flagN] = aluRes[`DATA_W-1];
			nextFlags[flagZ] = (aluRes == '0);
			nextFlags[flagV] = arith ? ovf : 1'b0;
		end
	end

	// addz sees Z from the instruction just ahead of it
	assign willWrite = oValid && oWe && !oHlt && !halted &&
	                   !(oCond && !flags[flagZ]);

	// Forward source for the operand stage
	assign fwdValid = willWrite;
	assign fwdData  = aluRes;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbValid <= 1'b0;
			flags   <= '0;
			halted  <= 1'b0;
		end else begin
			wbValid <= willWrite;
			flags   <= nextFlags;
			// Sticky until reset
			halted  <= halted || (oValid && oHlt);
		end
	end

	always_ff @(posedge clk) begin
		if (willWrite) begin
			wbAddr <= oDst;
			wbData <= aluRes;
		end
	end

endmodule

`default_nettype wire

//--- cpu_core.sv
// Core top level
// Decode, operand and execute stages around the register file

`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_core import isa_pkg::*; (
	input  logic               clk,
	input  logic               arstN,
	input  logic               instrValid,
	input  instrU              instr,
	output logic               wbValid,
	output logic [`REG_AW-1:0] wbAddr,
	output logic [`DATA_W-1:0] wbData,
	output logic [2:0]         flags,
	output logic               halted
);

	// Decode to operand stage
	logic               dValid;
	logic [2:0]         dFunc;
	logic [`REG_AW-1:0] dDst;
	logic [`REG_AW-1:0] dRs0;
	logic [`REG_AW-1:0] dRs1;
	logic               dRe0;
	logic               dRe1;
	logic               dImmSel;
	logic [7:0]         dImm;
	logic [3:0]         dShamt;
	logic               dWe;
	logic               dCond;
	logic               dHlt;

	// Register file reads
	logic [`REG_AW-1:0] rdAddr0;
	logic [`REG_AW-1:0] rdAddr1;
	logic [`DATA_W-1:0] rdData0;
	logic [`DATA_W-1:0] rdData1;

	// Operand to execute stage
	logic               oValid;
	logic [2:0]         oFunc;
	logic [`REG_AW-1:0] oDst;
	logic [`DATA_W-1:0] oA;
	logic [`DATA_W-1:0] oB;
	logic [3:0]         oShamt;
	logic               oWe;
	logic               oCond;
	logic               oHlt;

	// Forward path from execute
	logic               fwdValid;
	logic [`DATA_W-1:0] fwdData;

	instr_decode instr_decode_i (
		.clk        (clk),
		.arstN      (arstN),
		.instrValid (instrValid),
		.instr      (instr),
		.dValid     (dValid),
		.dFunc      (dFunc),
		.dDst       (dDst),
		.dRs0       (dRs0),
		.dRs1       (dRs1),
		.dRe0       (dRe0),
		.dRe1       (dRe1),
		.dImmSel    (dImmSel),
		.dImm       (dImm),
		.dShamt     (dShamt),
		.dWe        (dWe),
		.dCond      (dCond),
		.dHlt       (dHlt)
	);

	operand_stage operand_stage_i (
		.clk      (clk),
		.arstN    (arstN),
		.dValid   (dValid),
		.dFunc    (dFunc),
		.dDst     (dDst),
		.dRs0     (dRs0),
		.dRs1     (dRs1),
		.dRe0     (dRe0),
		.dRe1     (dRe1),
		.dImmSel  (dImmSel),
		.dImm     (dImm),
		.dShamt   (dShamt),
		.dWe      (dWe),
		.dCond    (dCond),
		.dHlt     (dHlt),
		.rdAddr0  (rdAddr0),
		.rdAddr1  (rdAddr1),
		.rdData0  (rdData0),
		.rdData1  (rdData1),
		.fwdValid (fwdValid),
		// Execute holds the instruction whose dst is oDst
		.fwdAddr  (oDst),
		.fwdData  (fwdData),
		.oValid   (oValid),
		.oFunc    (oFunc),
		.oDst     (oDst),
		.oA       (oA),
		.oB       (oB),
		.oShamt   (oShamt),
		.oWe      (oWe),
		.oCond    (oCond),
		.oHlt     (oHlt)
	);

	execute_stage execute_stage_i (
		.clk      (clk),
		.arstN    (arstN),
		.oValid   (oValid),
		.oFunc    (oFunc),
		.oDst     (oDst),
		.oA       (oA),
		.oB       (oB),
		.oShamt   (oShamt),
		.oWe      (oWe),
		.oCond    (oCond),
		.oHlt     (oHlt),
		.fwdValid (fwdValid),
		.fwdData  (fwdData),
		.wbValid  (wbValid),
		.wbAddr   (wbAddr),
		.wbData   (wbData),
		.flags    (flags),
		.halted   (halted)
	);

	// Write-back ports double as the write port
	reg_file reg_file_i (
		.clk     (clk),
		.arstN   (arstN),
		.rdAddr0 (rdAddr0),
		.rdAddr1 (rdAddr1),
		.rdData0 (rdData0),
		.rdData1 (rdData1),
		.wrEn    (wbValid),
		.wrAddr  (wbAddr),
		.wrData  (wbData)
	);

endmodule

`default_nettype wire

//--- cpu_core_asserts.sv
// Concurrent checks on write-back and halt outputs
// Bound into every cpu_core instance

`timescale 1ns/1ps
`default_nettype none

module cpu_core_asserts (
	input logic clk,
	input logic arstN,
	input logic wbValid,
	input logic halted
);

	// Nothing retires once the core has stopped
	noWbAfterHalt: assert property (@(posedge clk) disable iff (!arstN)
		halted |=> !wbValid)
		else $error("write-back while halted");

	// Sticky halt
	haltHolds: assert property (@(posedge clk) disable iff (!arstN)
		halted |=> halted)
		else $error("halted fell without reset");

	// Quiet write-back port during reset
	noWbInReset: assert property (@(posedge clk)
		(!arstN && $past(!arstN)) |-> !wbValid)
		else $error("write-back during reset");

endmodule

bind cpu_core cpu_core_asserts cpu_core_asserts_i (
	.clk     (clk),
	.arstN   (arstN),
	.wbValid (wbValid),
	.halted  (halted)
);

`default_nettype wire

//--- cpu_core_tb.sv
// Testbench for the three-stage core
// Stimulus table with LFSR gaps, write-back scoreboard and compare tasks

`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_core_tb import isa_pkg::*; ();

	// One table row with the instruction and its expected effects
	typedef struct packed {
		instrU              ins;
		logic               tight;
		logic               expWr;
		logic [`REG_AW-1:0] expReg;
		logic [`DATA_W-1:0] expVal;
		logic [2:0]         expFlg;
	} stepT;

	logic               clk;
	logic               arstN;
	logic               instrValid;
	instrU              instr;
	logic               wbValid;
	logic [`REG_AW-1:0] wbAddr;
	logic [`DATA_W-1:0] wbData;
	logic [2:0]         flags;
	logic               halted;

	stepT        steps[$];
	int          sb[$];
	logic [31:0] lfsr;

	cpu_core cpu_core_i (
		.clk        (clk),
		.arstN      (arstN),
		.instrValid (instrValid),
		.instr      (instr),
		.wbValid    (wbValid),
		.wbAddr     (wbAddr),
		.wbData     (wbData),
		.flags      (flags),
		.halted     (halted)
	);

	// 40 ns period
	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] nextLfsr(input logic [31:0] s);
		nextLfsr = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic instrU encodeReg(input logic [3:0] op, input logic [3:0] dst,
		input logic [3:0] src1, input logic [3:0] src0);
		encodeReg = {op, dst, src1, src0};
	endfunction

	function automatic instrU encodeImm(input logic [3:0] op, input logic [3:0] dst,
		input logic [7:0] imm);
		encodeImm = {op, dst, imm};
	endfunction

	task automatic addStep(input instrU ins, input logic tight, input logic expWr,
		input logic [3:0] expReg, input logic [15:0] expVal, input logic [2:0] expFlg);
		stepT s;
		s.ins    = ins;
		s.tight  = tight;
		s.expWr  = expWr;
		s.expReg = expReg;
		s.expVal = expVal;
		s.expFlg = expFlg;
		steps.push_back(s);
	endtask

	task automatic stopRun();
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic checkWb(input logic [`REG_AW-1:0] gotAddr, input logic [`DATA_W-1:0] gotData,
		input logic [`REG_AW-1:0] expAddr, input logic [`DATA_W-1:0] expData);
		if (gotAddr !== expAddr || gotData !== expData) begin
			$display("MISMATCH at %0t: write r%0d = %h, expected r%0d = %h",
				$time, gotAddr, gotData, expAddr, expData);
			stopRun();
		end
	endtask

	task automatic checkFlags(input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: flags NZV = %b, expected %b", $time, got, exp);
			stopRun();
		end
	endtask

	task automatic checkHalt(input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: halted = %b, expected %b", $time, got, exp);
			stopRun();
		end
	endtask

	// Program with expected flags as {N, Z, V}
	task automatic buildTable();
		// Constants from llb then lhb
		addStep(encodeImm(opLlb, 4'd1, 8'h34), 1'b0, 1'b1, 4'd1, 16'h0034, 3'b000);
		addStep(encodeImm(opLhb, 4'd1, 8'h12), 1'b1, 1'b1, 4'd1, 16'h1234, 3'b000);
		addStep(encodeImm(opLlb, 4'd2, 8'hf0), 1'b0, 1'b1, 4'd2, 16'hfff0, 3'b000);
		addStep(encodeImm(opLhb, 4'd2, 8'h7f), 1'b1, 1'b1, 4'd2, 16'h7ff0, 3'b000);
		addStep(encodeImm(opLlb, 4'd3, 8'h80), 1'b0, 1'b1, 4'd3, 16'hff80, 3'b000);
		addStep(encodeImm(opLhb, 4'd3, 8'h00), 1'b0, 1'b1, 4'd3, 16'h0080, 3'b000);
		addStep(encodeImm(opLlb, 4'd4, 8'h01), 1'b0, 1'b1, 4'd4, 16'h0001, 3'b000);
		addStep(encodeImm(opLhb, 4'd4, 8'h80), 1'b0, 1'b1, 4'd4, 16'h8001, 3'b000);
		addStep(encodeImm(opLlb, 4'd0, 8'h05), 1'b0, 1'b1, 4'd0, 16'h0005, 3'b000);
		// Dependent chain without gaps uses forward and write-through
		addStep(encodeReg(opAdd, 4'd5, 4'd1, 4'd0), 1'b0, 1'b1, 4'd5, 16'h1239, 3'b000);
		addStep(encodeReg(opSub, 4'd6, 4'd5, 4'd1), 1'b1, 1'b1, 4'd6, 16'h0005, 3'b000);
		addStep(encodeReg(opAnd, 4'd7, 4'd6, 4'd5), 1'b1, 1'b1, 4'd7, 16'h0001, 3'b000);
		addStep(encodeReg(opNor, 4'd8, 4'd7, 4'd3), 1'b1, 1'b1, 4'd8, 16'hff7e, 3'b100);
		addStep(encodeReg(opAdd, 4'd9, 4'd8, 4'd7), 1'b1, 1'b1, 4'd9, 16'hff7f, 3'b100);
		addStep(encodeReg(opSub, 4'd9, 4'd9, 4'd8), 1'b1, 1'b1, 4'd9, 16'h0001, 3'b000);
		// Shifts with the amount in the src0 field
		addStep(encodeReg(opSll, 4'd10, 4'd1, 4'd4), 1'b0, 1'b1, 4'd10, 16'h2340, 3'b000);
		addStep(encodeReg(opSrl, 4'd11, 4'd4, 4'd3), 1'b0, 1'b1, 4'd11, 16'h1000, 3'b000);
		addStep(encodeReg(opSra, 4'd12, 4'd4, 4'd3), 1'b0, 1'b1, 4'd12, 16'hf000, 3'b100);
		addStep(encodeReg(opSra, 4'd12, 4'd12, 4'd12), 1'b1, 1'b1, 4'd12, 16'hffff, 3'b100);
		addStep(encodeReg(opSll, 4'd13, 4'd4, 4'd15), 1'b0, 1'b1, 4'd13, 16'h8000, 3'b100);
		addStep(encodeReg(opSrl, 4'd14, 4'd13, 4'd15), 1'b1, 1'b1, 4'd14, 16'h0001, 3'b000);
		addStep(encodeReg(opSll, 4'd13, 4'd3, 4'd0), 1'b0, 1'b1, 4'd13, 16'h0080, 3'b000);
		addStep(encodeReg(opSrl, 4'd14, 4'd3, 4'd8), 1'b0, 1'b1, 4'd14, 16'h0000, 3'b010);
		// Signed overflow both ways
		addStep(encodeReg(opAdd, 4'd15, 4'd2, 4'd2), 1'b0, 1'b1, 4'd15, 16'hffe0, 3'b101);
		addStep(encodeReg(opSub, 4'd15, 4'd4, 4'd1), 1'b0, 1'b1, 4'd15, 16'h6dcd, 3'b001);
		addStep(encodeReg(opSub, 4'd5, 4'd2, 4'd4), 1'b0, 1'b1, 4'd5, 16'hffef, 3'b101);
		addStep(encodeReg(opSub, 4'd6, 4'd1, 4'd1), 1'b0, 1'b1, 4'd6, 16'h0000, 3'b010);
		// addz writes after Z set and only moves flags after Z clear
		addStep(encodeReg(opAddz, 4'd7, 4'd1, 4'd0), 1'b1, 1'b1, 4'd7, 16'h1239, 3'b000);
		addStep(encodeReg(opAddz, 4'd8, 4'd2, 4'd2), 1'b1, 1'b0, 4'd8, 16'h0000, 3'b101);
		addStep(encodeImm(opLlb, 4'd9, 8'h11), 1'b1, 1'b1, 4'd9, 16'h0011, 3'b101);
		// r8 must still hold the nor result
		addStep(encodeReg(opAnd, 4'd10, 4'd8, 4'd8), 1'b1, 1'b1, 4'd10, 16'hff7e, 3'b100);
		addStep(encodeReg(opAnd, 4'd11, 4'd1, 4'd14), 1'b0, 1'b1, 4'd11, 16'h0000, 3'b010);
		addStep(encodeReg(opAddz, 4'd11, 4'd3, 4'd3), 1'b1, 1'b1, 4'd11, 16'h0100, 3'b000);
		// Nothing retires after halt
		addStep(encodeReg(opHlt, 4'd0, 4'd0, 4'd0), 1'b0, 1'b0, 4'd0, 16'h0000, 3'b000);
		addStep(encodeImm(opLlb, 4'd1, 8'h55), 1'b0, 1'b0, 4'd1, 16'h0000, 3'b000);
		// Dropped sub would set Z if it reached the flags
		addStep(encodeReg(opSub, 4'd2, 4'd1, 4'd1), 1'b1, 1'b0, 4'd2, 16'h0000, 3'b000);
	endtask

	// Scoreboard pop on every write-back at the falling edge
	always @(negedge clk) begin
		int idx;
		if (arstN === 1'b1 && wbValid === 1'b1) begin
			if (sb.size() == 0) begin
				$display("Write-back to r%0d at %0t with no write expected", wbAddr, $time);
				stopRun();
			end else begin
				idx = sb.pop_front();
				checkWb(wbAddr, wbData, steps[idx].expReg, steps[idx].expVal);
				checkFlags(flags, steps[idx].expFlg);
			end
		end
	end

	initial begin
		logic [1:0] gap;
		int         waitCnt;
		arstN      = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		lfsr       = 32'h16e0;
		buildTable();

		repeat (10) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkHalt(halted, 1'b0);
		checkFlags(flags, 3'b000);

		foreach (steps[i]) begin
			// Two LFSR steps give 0 to 3 idle cycles
			gap = 2'd0;
			if (!steps[i].tight) begin
				lfsr   = nextLfsr(lfsr);
				gap[0] = lfsr[0];
				lfsr   = nextLfsr(lfsr);
				gap[1] = lfsr[0];
			end
			repeat (gap) begin
				@(posedge clk);
				instrValid <= 1'b0;
			end
			@(posedge clk);
			instrValid <= 1'b1;
			instr      <= steps[i].ins;
			if (steps[i].expWr) begin
				sb.push_back(i);
			end
		end
		@(posedge clk);
		instrValid <= 1'b0;

		// Halt must arrive within a few cycles
		waitCnt = 0;
		@(negedge clk);
		while (halted !== 1'b1) begin
			waitCnt++;
			if (waitCnt > 50) begin
				$display("Timeout waiting for halted to rise");
				stopRun();
			end
			@(negedge clk);
		end

		// Quiet window where the monitor catches any late write
		repeat (20) @(negedge clk);
		checkHalt(halted, 1'b1);
		checkFlags(flags, steps[steps.size() - 1].expFlg);

		@(posedge clk);
		if (sb.size() != 0) begin
			$display("%0d expected write-backs never appeared", sb.size());
			stopRun();
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
isa_pkg.sv
alu_pkg.sv
instr_decode.sv
reg_file.sv
operand_stage.sv
execute_stage.sv
cpu_core.sv
cpu_core_asserts.sv
cpu_core_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - alu_pkg.sv
      - instr_decode.sv
      - reg_file.sv
      - operand_stage.sv
      - execute_stage.sv
      - cpu_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpu_core_asserts.sv
      - cpu_core_tb.sv
